//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_draw_rect_char
FILELIST  = compile.f
BUILD_DIR = obj_dir
SIM_BIN   = $(BUILD_DIR)/V$(TOP)
SIM_ARGS  = +verilator+error+limit+1000
LOG       = sim.log
FAIL_MSG  = Something failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "run failed"; exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/draw_rect_char_props.sv
`timescale 1ns/100ps

module draw_rect_char_props (
    input logic                    pclk,
    input logic                    rst,
    input logic                    hsync_in,
    input logic                    hsync_out,
    input overlay_pkg::coord_t     vcount_in,
    input logic                    box_hit,
    input overlay_pkg::screen_t    screen,
    input overlay_pkg::char_line_t char_line,
    input overlay_pkg::rgb_t       rgb_out
);

    int assert_fails = 0; // read by the testbench at the end

    // glyph line relative to the top of the active box
    function automatic overlay_pkg::char_line_t rel_line(
        input overlay_pkg::coord_t  v,
        input overlay_pkg::screen_t s
    );
        overlay_pkg::coord_t top;
        overlay_pkg::coord_t diff;
        top = (s == overlay_pkg::SCREEN_PLAY) ? 11'd600 : 11'd300;
        diff = v - top;
        rel_line = diff[3:0];
    endfunction

    ////////////////////////////////////////////////////////////
    // properties
    ////////////////////////////////////////////////////////////

    rgb_cleared_by_reset: assert property (@(posedge pclk) rst |=> rgb_out == '0)
        else begin $error("rgb_out not zero after a reset cycle"); assert_fails++; end

    // three register stages, none of them in reset
    hsync_three_late: assert property (@(posedge pclk) disable iff (rst)
        (!$past(rst) && !$past(rst, 2) && !$past(rst, 3)) |-> hsync_out == $past(hsync_in, 3))
        else begin $error("hsync_out does not match hsync_in of 3 edges before"); assert_fails++; end

    line_follows_vcount: assert property (@(posedge pclk) disable iff (rst)
        box_hit |-> char_line == rel_line($past(vcount_in), screen))
        else begin $error("char_line differs from the relative line"); assert_fails++; end

    rgb_known: assert property (@(posedge pclk) disable iff (rst) !$isunknown(rgb_out))
        else begin $error("rgb_out has unknown bits"); assert_fails++; end

endmodule

bind draw_rect_char draw_rect_char_props u_props (
    .pclk      (pclk),
    .rst       (rst),
    .hsync_in  (hsync_in),
    .hsync_out (hsync_out),
    .vcount_in (vcount_in),
    .box_hit   (box_hit),
    .screen    (screen),
    .char_line (char_line),
    .rgb_out   (rgb_out)
);

//--- bench/tb_draw_rect_char.sv
`timescale 1ns/100ps

module tb_draw_rect_char;

    localparam logic [11:0] LETTER = 12'h333;
    localparam logic [11:0] BOX_BG = 12'heee;
    localparam logic [11:0] TITLE  = 12'hf00;
    localparam logic [11:0] YELLOW = 12'hff0;
    localparam logic [11:0] BLUE   = 12'h00f;
    localparam logic [11:0] GRAY   = 12'h888;

    // mode is {start_en, choice_en, game_over}
    localparam logic [2:0] MODE_PLAY   = 3'b000;
    localparam logic [2:0] MODE_OVER   = 3'b001;
    localparam logic [2:0] MODE_CHOICE = 3'b110;
    localparam logic [2:0] MODE_IDLE   = 3'b100;

    localparam int PASS_N       = 64;
    localparam int BOX_N        = 48;
    localparam int IDLE_N       = 16;
    localparam int IDLE_FIXED_N = 5;   // idle points on areas drawn elsewhere
    localparam int POINT_CYCLES = 4;   // drive edge plus 3 pipeline edges
    localparam int TOTAL_CYCLES = 3 + (PASS_N + 3) + 4 * POINT_CYCLES
                                  + BOX_N * POINT_CYCLES + (BOX_N + 1) * POINT_CYCLES
                                  + (2 + IDLE_FIXED_N + IDLE_N) * POINT_CYCLES;

    logic                    pclk;
    logic                    rst;
    overlay_pkg::coord_t     hcount_in;
    overlay_pkg::coord_t     vcount_in;
    logic                    hsync_in;
    logic                    vsync_in;
    logic                    hblnk_in;
    logic                    vblnk_in;
    logic                    start_en;
    logic                    choice_en;
    logic                    game_over;
    overlay_pkg::font_row_t  char_pixels = '0;
    overlay_pkg::char_xy_t   char_xy;
    overlay_pkg::char_line_t char_line;
    overlay_pkg::coord_t     hcount_out;
    overlay_pkg::coord_t     vcount_out;
    logic                    hsync_out;
    logic                    vsync_out;
    logic                    hblnk_out;
    logic                    vblnk_out;
    overlay_pkg::rgb_t       rgb_out;

    logic [31:0] rng_state;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;

    draw_rect_char u_draw_rect_char (.*);

    // font rom, one cycle of latency
    always @(posedge pclk)
        char_pixels <= char_xy ^ {char_line, char_line};

    initial
    begin
        pclk = 1'b0;
        forever #5 pclk = ~pclk;
    end

    initial
    begin
        #(2 * TOTAL_CYCLES * 10);
        $display("watchdog expired after %0d cycles, the tests did not finish", 2 * TOTAL_CYCLES);
        $display("Something failed");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_random(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[ERROR] t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
        test_errors++;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        errors += test_errors;
        if (test_errors == 0)
            $display("test %s: passed", name);
        else
        begin
            tests_failed++;
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    ////////////////////////////////////////////////////////////
    // point drivers
    ////////////////////////////////////////////////////////////

    task automatic run_point(
        input logic [2:0]              mode,
        input overlay_pkg::coord_t     h,
        input overlay_pkg::coord_t     v,
        input logic                    chk_char,
        input overlay_pkg::char_xy_t   exp_xy,
        input overlay_pkg::char_line_t exp_line,
        input overlay_pkg::rgb_t       exp_rgb
    );
        @(posedge pclk);
        #1;
        {start_en, choice_en, game_over} = mode;
        hcount_in = h;
        vcount_in = v;
        @(posedge pclk);
        #1;
        if (chk_char && char_xy !== exp_xy)
            report_mismatch("char_xy", char_xy, exp_xy);
        if (chk_char && char_line !== exp_line)
            report_mismatch("char_line", char_line, exp_line);
        repeat (2) @(posedge pclk);
        #1;
        if (hcount_out !== h)
            report_mismatch("hcount_out", hcount_out, h);
        if (vcount_out !== v)
            report_mismatch("vcount_out", vcount_out, v);
        if (rgb_out !== exp_rgb)
            report_mismatch("rgb_out", rgb_out, exp_rgb);
    endtask

    task automatic shape_point(input logic [2:0] mode, input overlay_pkg::coord_t h,
                               input overlay_pkg::coord_t v, input overlay_pkg::rgb_t exp_rgb);
        run_point(mode, h, v, 1'b0, '0, '0, exp_rgb);
    endtask

    // random point inside a text box, expected glyph bit from the rom rule
    task automatic box_point(input logic [2:0] mode, input overlay_pkg::coord_t bx,
                             input overlay_pkg::coord_t by, input int w);
        logic [31:0]             r;
        overlay_pkg::coord_t     h;
        overlay_pkg::coord_t     v;
        overlay_pkg::coord_t     rel_h;
        overlay_pkg::coord_t     rel_v;
        overlay_pkg::char_xy_t   xy;
        overlay_pkg::char_line_t line;
        overlay_pkg::font_row_t  row;
        overlay_pkg::rgb_t       col;
        logic [2:0]              bit_idx;
        next_random(r);
        h = bx + overlay_pkg::coord_t'(r[15:0] % w);
        v = by + overlay_pkg::coord_t'(r[31:16] % 15);
        rel_h = h - bx;
        rel_v = v - by;
        // cells are 8 pixels wide and 16 lines high
        xy = {4'(rel_v / 16), 4'(rel_h / 8)};
        line = 4'(rel_v % 16);
        row = xy ^ {line, line};
        bit_idx = 3'd7 - 3'(rel_h % 8); // msb is leftmost pixel
        col = row[bit_idx] ? LETTER : BOX_BG;
        run_point(mode, h, v, 1'b1, xy, line, col);
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset();
        repeat (3)
        begin
            @(posedge pclk);
            #1;
            if (char_xy !== '0)    report_mismatch("char_xy", char_xy, 0);
            if (char_line !== '0)  report_mismatch("char_line", char_line, 0);
            if (hcount_out !== '0) report_mismatch("hcount_out", hcount_out, 0);
            if (vcount_out !== '0) report_mismatch("vcount_out", vcount_out, 0);
            if (hsync_out !== 1'b0) report_mismatch("hsync_out", hsync_out, 0);
            if (vsync_out !== 1'b0) report_mismatch("vsync_out", vsync_out, 0);
            if (hblnk_out !== 1'b0) report_mismatch("hblnk_out", hblnk_out, 0);
            if (vblnk_out !== 1'b0) report_mismatch("vblnk_out", vblnk_out, 0);
            if (rgb_out !== '0)    report_mismatch("rgb_out", rgb_out, 0);
        end
        rst = 1'b0;
        finish_test("reset");
    endtask

    // new random values every cycle, compared 3 edges later
    task automatic test_timing();
        overlay_pkg::coord_t hist_h [PASS_N];
        overlay_pkg::coord_t hist_v [PASS_N];
        logic [3:0]          hist_s [PASS_N]; // hsync, vsync, hblnk, vblnk
        logic [31:0]         r1;
        logic [31:0]         r2;
        int                  j;
        for (int i = 0; i < PASS_N + 3; i++)
        begin
            @(posedge pclk);
            #1;
            j = i - 3;
            if (i >= 3)
            begin
                if (hcount_out !== hist_h[j]) report_mismatch("hcount_out", hcount_out, hist_h[j]);
                if (vcount_out !== hist_v[j]) report_mismatch("vcount_out", vcount_out, hist_v[j]);
                if (hsync_out !== hist_s[j][3]) report_mismatch("hsync_out", hsync_out, hist_s[j][3]);
                if (vsync_out !== hist_s[j][2]) report_mismatch("vsync_out", vsync_out, hist_s[j][2]);
                if (hblnk_out !== hist_s[j][1]) report_mismatch("hblnk_out", hblnk_out, hist_s[j][1]);
                if (vblnk_out !== hist_s[j][0]) report_mismatch("vblnk_out", vblnk_out, hist_s[j][0]);
            end
            if (i < PASS_N)
            begin
                next_random(r1);
                next_random(r2);
                hist_h[i] = r1[10:0];
                hist_v[i] = r1[26:16];
                hist_s[i] = r2[3:0];
                hcount_in = hist_h[i];
                vcount_in = hist_v[i];
                {hsync_in, vsync_in, hblnk_in, vblnk_in} = hist_s[i];
                {start_en, choice_en, game_over} = r2[6:4]; // any screen
            end
        end
        {hsync_in, vsync_in, hblnk_in, vblnk_in} = 4'b0;
        finish_test("timing pass-through");
    endtask

    task automatic test_play_shapes();
        shape_point(MODE_PLAY, 11'd130, 11'd200, TITLE);
        shape_point(MODE_PLAY, 11'd440, 11'd410, YELLOW);
        shape_point(MODE_PLAY, 11'd520, 11'd500, BLUE);
        shape_point(MODE_PLAY, 11'd20, 11'd20, GRAY);
        finish_test("play shapes");
    endtask

    task automatic test_play_box();
        repeat (BOX_N) box_point(MODE_PLAY, 11'd490, 11'd600, 40);
        finish_test("play text box");
    endtask

    task automatic test_game_over();
        repeat (BOX_N) box_point(MODE_OVER, 11'd470, 11'd300, 110);
        shape_point(MODE_OVER, 11'd130, 11'd200, GRAY); // title gone
        finish_test("game over");
    endtask

    task automatic test_choice_idle();
        logic [31:0] r;
        shape_point(MODE_CHOICE, 11'd350, 11'd500, BLUE);
        shape_point(MODE_CHOICE, 11'd700, 11'd500, YELLOW);
        // title, squares and both boxes of the other screens
        shape_point(MODE_IDLE, 11'd130, 11'd200, GRAY);
        shape_point(MODE_IDLE, 11'd440, 11'd410, GRAY);
        shape_point(MODE_IDLE, 11'd350, 11'd500, GRAY);
        shape_point(MODE_IDLE, 11'd500, 11'd305, GRAY);
        shape_point(MODE_IDLE, 11'd500, 11'd605, GRAY);
        repeat (IDLE_N)
        begin
            next_random(r);
            shape_point(MODE_IDLE, {1'b0, r[9:0]}, overlay_pkg::coord_t'(r[25:16] % 768), GRAY);
        end
        finish_test("choice and idle");
    endtask

    initial
    begin
        rst = 1'b1;
        hcount_in = '0;
        vcount_in = '0;
        hsync_in = 1'b0;
        vsync_in = 1'b0;
        hblnk_in = 1'b0;
        vblnk_in = 1'b0;
        start_en = 1'b0;
        choice_en = 1'b0;
        game_over = 1'b0;
        rng_state = 32'he39ae91b;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;

        test_reset();
        test_timing();
        test_play_shapes();
        test_play_box();
        test_game_over();
        test_choice_idle();

        if (u_draw_rect_char.u_props.assert_fails != 0)
        begin
            $display("%0d assertion failures seen", u_draw_rect_char.u_props.assert_fails);
            errors += u_draw_rect_char.u_props.assert_fails;
        end
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

//--- compile.f
+incdir+verilog
verilog/overlay_pkg.sv
verilog/glyph_fetch.sv
verilog/shape_painter.sv
verilog/overlay_mixer.sv
verilog/draw_rect_char.sv
bench/draw_rect_char_props.sv
bench/tb_draw_rect_char.sv

//--- verilog/draw_rect_char.sv
`timescale 1ns/100ps

module draw_rect_char (
    input  logic                    pclk,
    input  logic                    rst,
    input  overlay_pkg::coord_t     hcount_in,
    input  overlay_pkg::coord_t     vcount_in,
    input  logic                    hsync_in,
    input  logic                    vsync_in,
    input  logic                    hblnk_in,
    input  logic                    vblnk_in,
    input  logic                    start_en,
    input  logic                    choice_en,
    input  logic                    game_over,
    input  overlay_pkg::font_row_t  char_pixels,
    output overlay_pkg::char_xy_t   char_xy,
    output overlay_pkg::char_line_t char_line,
    output overlay_pkg::coord_t     hcount_out,
    output overlay_pkg::coord_t     vcount_out,
    output logic                    hsync_out,
    output logic                    vsync_out,
    output logic                    hblnk_out,
    output logic                    vblnk_out,
    output overlay_pkg::rgb_t       rgb_out
);

    // stage 1 to mixer
    logic                 box_hit;
    logic [2:0]           glyph_col;
    overlay_pkg::screen_t screen;
    overlay_pkg::coord_t  hcount_d;
    overlay_pkg::coord_t  vcount_d;
    logic                 hsync_d;
    logic                 vsync_d;
    logic                 hblnk_d;
    logic                 vblnk_d;

    // painter to mixer
    logic                 shape_hit;
    overlay_pkg::rgb_t    shape_rgb;

    glyph_fetch u_glyph_fetch (
        .pclk      (pclk),
        .rst       (rst),
        .hcount_in (hcount_in),
        .vcount_in (vcount_in),
        .hsync_in  (hsync_in),
        .vsync_in  (vsync_in),
        .hblnk_in  (hblnk_in),
        .vblnk_in  (vblnk_in),
        .start_en  (start_en),
        .choice_en (choice_en),
        .game_over (game_over),
        .char_xy   (char_xy),
        .char_line (char_line),
        .box_hit   (box_hit),
        .glyph_col (glyph_col),
        .screen    (screen),
        .hcount_d  (hcount_d),
        .vcount_d  (vcount_d),
        .hsync_d   (hsync_d),
        .vsync_d   (vsync_d),
        .hblnk_d   (hblnk_d),
        .vblnk_d   (vblnk_d)
    );

    shape_painter u_shape_painter (
        .pclk      (pclk),
        .rst       (rst),
        .hcount_in (hcount_in),
        .vcount_in (vcount_in),
        .start_en  (start_en),
        .choice_en (choice_en),
        .game_over (game_over),
        .shape_hit (shape_hit),
        .shape_rgb (shape_rgb)
    );

    overlay_mixer u_overlay_mixer (
        .pclk        (pclk),
        .rst         (rst),
        .box_hit     (box_hit),
        .glyph_col   (glyph_col),
        .screen      (screen),
        .hcount_d    (hcount_d),
        .vcount_d    (vcount_d),
        .hsync_d     (hsync_d),
        .vsync_d     (vsync_d),
        .hblnk_d     (hblnk_d),
        .vblnk_d     (vblnk_d),
        .shape_hit   (shape_hit),
        .shape_rgb   (shape_rgb),
        .char_pixels (char_pixels),
        .hcount_out  (hcount_out),
        .vcount_out  (vcount_out),
        .hsync_out   (hsync_out),
        .vsync_out   (vsync_out),
        .hblnk_out   (hblnk_out),
        .vblnk_out   (vblnk_out),
        .rgb_out     (rgb_out)
    );

endmodule

//--- verilog/glyph_fetch.sv
`timescale 1ns/100ps

`include "overlay_defines.svh"

module glyph_fetch (
    input  logic                    pclk,
    input  logic                    rst,
    input  overlay_pkg::coord_t     hcount_in,
    input  overlay_pkg::coord_t     vcount_in,
    input  logic                    hsync_in,
    input  logic                    vsync_in,
    input  logic                    hblnk_in,
    input  logic                    vblnk_in,
    input  logic                    start_en,
    input  logic                    choice_en,
    input  logic                    game_over,
    output overlay_pkg::char_xy_t   char_xy,
    output overlay_pkg::char_line_t char_line,
    output logic                    box_hit,
    output logic [2:0]              glyph_col,
    output overlay_pkg::screen_t    screen,
    output overlay_pkg::coord_t     hcount_d,
    output overlay_pkg::coord_t     vcount_d,
    output logic                    hsync_d,
    output logic                    vsync_d,
    output logic                    hblnk_d,
    output logic                    vblnk_d
);

    overlay_pkg::screen_t screen_nxt;
    overlay_pkg::coord_t  box_x;
    overlay_pkg::coord_t  box_y;
    overlay_pkg::coord_t  box_w;
    overlay_pkg::coord_t  rel_h;
    overlay_pkg::coord_t  rel_v;
    logic                 box_en;
    logic                 in_box;

    ////////////////////////////////////////////////////////////
    // box window select
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        screen_nxt = overlay_pkg::screen_of(start_en, choice_en, game_over);
        box_en = 1'b1;
        box_x  = `MSG_BOX_X;  // over and choice share this box
        box_y  = `MSG_BOX_Y;
        box_w  = `MSG_BOX_W;
        case (screen_nxt)
            overlay_pkg::SCREEN_PLAY:
            begin
                box_x = `PLAY_BOX_X;
                box_y = `PLAY_BOX_Y;
                box_w = `PLAY_BOX_W;
            end
            overlay_pkg::SCREEN_IDLE: box_en = 1'b0;
            default: box_en = 1'b1;
        endcase
        rel_h  = hcount_in - box_x;
        rel_v  = vcount_in - box_y;
        in_box = box_en
                 && (hcount_in >= box_x) && (hcount_in < box_x + box_w)
                 && (vcount_in >= box_y) && (vcount_in < box_y + `BOX_H);
    end

    always_ff @(posedge pclk)
    begin
        if (rst)
        begin
            char_xy   <= '0;
            char_line <= '0;
            box_hit   <= 1'b0;
            screen    <= overlay_pkg::SCREEN_IDLE;
            hsync_d   <= 1'b0;
            vsync_d   <= 1'b0;
            hblnk_d   <= 1'b0;
            vblnk_d   <= 1'b0;
        end
        else
        begin
            char_xy   <= {rel_v[7:4], rel_h[6:3]}; // 16 px rows, 8 px columns
            char_line <= rel_v[3:0];
            box_hit   <= in_box;
            screen    <= screen_nxt;
            hsync_d   <= hsync_in;
            vsync_d   <= vsync_in;
            hblnk_d   <= hblnk_in;
            vblnk_d   <= vblnk_in;
        end
    end

    // payload, follows the raster
    always_ff @(posedge pclk)
    begin
        glyph_col <= rel_h[2:0];
        hcount_d  <= hcount_in;
        vcount_d  <= vcount_in;
    end

endmodule

//--- verilog/overlay_defines.svh
`ifndef OVERLAY_DEFINES_SVH
`define OVERLAY_DEFINES_SVH

////////////////////////////////////////////////////////////
// title lettering
////////////////////////////////////////////////////////////

// shift applied to every title stroke
`define TITLE_DX     11'd100
`define TITLE_DY     11'd100

// stroke rows before the shift
`define TITLE_TOP    11'd100
`define TITLE_MID    11'd150
`define TITLE_BOT    11'd200

////////////////////////////////////////////////////////////
// text boxes
////////////////////////////////////////////////////////////

`define PLAY_BOX_X   11'd490  // play screen box
`define PLAY_BOX_Y   11'd600
`define PLAY_BOX_W   11'd40

`define MSG_BOX_X    11'd470  // game over and choice box
`define MSG_BOX_Y    11'd300
`define MSG_BOX_W    11'd110

`define BOX_H        11'd15

////////////////////////////////////////////////////////////
// squares
////////////////////////////////////////////////////////////

// play screen, two squares meeting at the mid point
`define SQ_A_X0      11'd430
`define SQ_A_Y0      11'd400
`define SQ_B_X1      11'd590
`define SQ_B_Y1      11'd560
`define SQ_MID_X     11'd510
`define SQ_MID_Y     11'd480

// choice screen, same rows for both squares
`define CHOICE_Y0    11'd450
`define CHOICE_Y1    11'd550
`define CHOICE_L_X0  11'd300
`define CHOICE_L_X1  11'd400
`define CHOICE_R_X0  11'd650
`define CHOICE_R_X1  11'd750

// 4:4:4 colours
`define COL_LETTER   12'h333
`define COL_BOX_BG   12'heee
`define COL_TITLE    12'hf00
`define COL_YELLOW   12'hff0
`define COL_BLUE     12'h00f
`define COL_GRAY     12'h888

`endif

//--- verilog/overlay_mixer.sv
`timescale 1ns/100ps

`include "overlay_defines.svh"

module overlay_mixer (
    input  logic                   pclk,
    input  logic                   rst,
    input  logic                   box_hit,
    input  logic [2:0]             glyph_col,
    input  overlay_pkg::screen_t   screen,
    input  overlay_pkg::coord_t    hcount_d,
    input  overlay_pkg::coord_t    vcount_d,
    input  logic                   hsync_d,
    input  logic                   vsync_d,
    input  logic                   hblnk_d,
    input  logic                   vblnk_d,
    input  logic                   shape_hit,
    input  overlay_pkg::rgb_t      shape_rgb,
    input  overlay_pkg::font_row_t char_pixels,
    output overlay_pkg::coord_t    hcount_out,
    output overlay_pkg::coord_t    vcount_out,
    output logic                   hsync_out,
    output logic                   vsync_out,
    output logic                   hblnk_out,
    output logic                   vblnk_out,
    output overlay_pkg::rgb_t      rgb_out
);

    logic                 box_hit_q;
    logic                 shape_hit_q;
    logic                 hsync_q;
    logic                 vsync_q;
    logic                 hblnk_q;
    logic                 vblnk_q;
    logic [2:0]           glyph_col_q;
    overlay_pkg::screen_t screen_q;
    overlay_pkg::coord_t  hcount_q;
    overlay_pkg::coord_t  vcount_q;
    overlay_pkg::rgb_t    shape_rgb_q;
    overlay_pkg::rgb_t    rgb_nxt;

    ////////////////////////////////////////////////////////////
    // wait one cycle for the font rom
    ////////////////////////////////////////////////////////////

    always_ff @(posedge pclk)
    begin
        if (rst)
        begin
            box_hit_q   <= 1'b0;
            shape_hit_q <= 1'b0;
            screen_q    <= overlay_pkg::SCREEN_IDLE;
            hsync_q     <= 1'b0;
            vsync_q     <= 1'b0;
            hblnk_q     <= 1'b0;
            vblnk_q     <= 1'b0;
        end
        else
        begin
            box_hit_q   <= box_hit;
            shape_hit_q <= shape_hit;
            screen_q    <= screen;
            hsync_q     <= hsync_d;
            vsync_q     <= vsync_d;
            hblnk_q     <= hblnk_d;
            vblnk_q     <= vblnk_d;
        end
    end

    always_ff @(posedge pclk)
    begin
        glyph_col_q <= glyph_col;
        shape_rgb_q <= shape_rgb;
        hcount_q    <= hcount_d;
        vcount_q    <= vcount_d;
    end

    // text box over shapes over background
    always_comb
    begin
        if (screen_q == overlay_pkg::SCREEN_IDLE)
            rgb_nxt = `COL_GRAY;
        else if (box_hit_q)
            rgb_nxt = char_pixels[3'd7 - glyph_col_q] ? `COL_LETTER : `COL_BOX_BG;
        else if (shape_hit_q)
            rgb_nxt = shape_rgb_q;
        else
            rgb_nxt = `COL_GRAY;
    end

    always_ff @(posedge pclk)
    begin
        if (rst)
        begin
            hcount_out <= '0;
            vcount_out <= '0;
            hsync_out  <= 1'b0;
            vsync_out  <= 1'b0;
            hblnk_out  <= 1'b0;
            vblnk_out  <= 1'b0;
            rgb_out    <= '0;
        end
        else
        begin
            hcount_out <= hcount_q;
            vcount_out <= vcount_q;
            hsync_out  <= hsync_q;
            vsync_out  <= vsync_q;
            hblnk_out  <= hblnk_q;
            vblnk_out  <= vblnk_q;
            rgb_out    <= rgb_nxt;
        end
    end

endmodule

//--- verilog/overlay_pkg.sv
package overlay_pkg;

    typedef logic [10:0] coord_t;     // pixel count
    typedef logic [11:0] rgb_t;       // 4:4:4 colour
    typedef logic [7:0]  char_xy_t;   // {row, column} of a character cell
    typedef logic [3:0]  char_line_t; // line within a glyph
    typedef logic [7:0]  font_row_t;  // glyph row, msb leftmost

    // what the overlay paints
    typedef enum logic [1:0]
    {
        SCREEN_IDLE   = 2'd0,
        SCREEN_PLAY   = 2'd1,
        SCREEN_OVER   = 2'd2,
        SCREEN_CHOICE = 2'd3
    } screen_t;

    // start_en low means a game is running or just ended
    function automatic screen_t screen_of(
        input logic start_en,
        input logic choice_en,
        input logic game_over
    );
        if (!start_en)
            screen_of = game_over ? SCREEN_OVER : SCREEN_PLAY;
        else if (choice_en)
            screen_of = SCREEN_CHOICE;
        else
            screen_of = SCREEN_IDLE; // start screen, nothing drawn
    endfunction

endpackage

//--- verilog/shape_painter.sv
`timescale 1ns/100ps

`include "overlay_defines.svh"

module shape_painter (
    input  logic                pclk,
    input  logic                rst,
    input  overlay_pkg::coord_t hcount_in,
    input  overlay_pkg::coord_t vcount_in,
    input  logic                start_en,
    input  logic                choice_en,
    input  logic                game_over,
    output logic                shape_hit,
    output overlay_pkg::rgb_t   shape_rgb
);

    overlay_pkg::screen_t screen_now;
    overlay_pkg::rgb_t    rgb_nxt;
    logic                 hit_nxt;
    logic                 title_hit;

    // horizontal stroke on title row y, columns x0..x1, shifted
    function automatic logic h_run(
        input overlay_pkg::coord_t h,
        input overlay_pkg::coord_t v,
        input overlay_pkg::coord_t y,
        input overlay_pkg::coord_t x0,
        input overlay_pkg::coord_t x1
    );
        h_run = (v == y + `TITLE_DY)
                && (h >= x0 + `TITLE_DX) && (h <= x1 + `TITLE_DX);
    endfunction

    // vertical stroke, always full letter height
    function automatic logic v_run(
        input overlay_pkg::coord_t h,
        input overlay_pkg::coord_t v,
        input overlay_pkg::coord_t x
    );
        v_run = (h == x + `TITLE_DX)
                && (v >= `TITLE_TOP + `TITLE_DY) && (v <= `TITLE_BOT + `TITLE_DY);
    endfunction

    ////////////////////////////////////////////////////////////
    // title strokes, T I C T A C T O E
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        title_hit =
            h_run(hcount_in, vcount_in, `TITLE_TOP, 11'd30, 11'd100)    // T
            | v_run(hcount_in, vcount_in, 11'd65)
            | v_run(hcount_in, vcount_in, 11'd120)                      // I
            | v_run(hcount_in, vcount_in, 11'd140)                      // C
            | h_run(hcount_in, vcount_in, `TITLE_TOP, 11'd140, 11'd210)
            | h_run(hcount_in, vcount_in, `TITLE_BOT, 11'd140, 11'd210)
            | h_run(hcount_in, vcount_in, `TITLE_TOP, 11'd250, 11'd320) // T
            | v_run(hcount_in, vcount_in, 11'd285)
            | v_run(hcount_in, vcount_in, 11'd340)                      // A
            | v_run(hcount_in, vcount_in, 11'd410)
            | h_run(hcount_in, vcount_in, `TITLE_TOP, 11'd340, 11'd410)
            | h_run(hcount_in, vcount_in, `TITLE_MID, 11'd340, 11'd410)
            | h_run(hcount_in, vcount_in, `TITLE_TOP, 11'd430, 11'd500) // C
            | h_run(hcount_in, vcount_in, `TITLE_BOT, 11'd430, 11'd500)
            | v_run(hcount_in, vcount_in, 11'd430)
            | h_run(hcount_in, vcount_in, `TITLE_TOP, 11'd540, 11'd610) // T
            | v_run(hcount_in, vcount_in, 11'd575)
            | h_run(hcount_in, vcount_in, `TITLE_TOP, 11'd630, 11'd700) // O
            | h_run(hcount_in, vcount_in, `TITLE_BOT, 11'd630, 11'd700)
            | v_run(hcount_in, vcount_in, 11'd630)
            | v_run(hcount_in, vcount_in, 11'd700)
            | v_run(hcount_in, vcount_in, 11'd720)                      // E
            | h_run(hcount_in, vcount_in, `TITLE_TOP, 11'd720, 11'd790)
            | h_run(hcount_in, vcount_in, `TITLE_MID, 11'd720, 11'd790)
            | h_run(hcount_in, vcount_in, `TITLE_BOT, 11'd720, 11'd790);
    end

    // first match wins
    always_comb
    begin
        screen_now = overlay_pkg::screen_of(start_en, choice_en, game_over);
        hit_nxt = 1'b1;
        rgb_nxt = `COL_GRAY;
        if (screen_now == overlay_pkg::SCREEN_PLAY && title_hit)
            rgb_nxt = `COL_TITLE;
        else if (screen_now == overlay_pkg::SCREEN_PLAY
                 && hcount_in >= `SQ_A_X0 && hcount_in <= `SQ_MID_X
                 && vcount_in >= `SQ_A_Y0 && vcount_in <= `SQ_MID_Y)
            rgb_nxt = `COL_YELLOW;
        else if (screen_now == overlay_pkg::SCREEN_PLAY
                 && hcount_in > `SQ_MID_X && hcount_in <= `SQ_B_X1
                 && vcount_in > `SQ_MID_Y && vcount_in <= `SQ_B_Y1)
            rgb_nxt = `COL_BLUE; // lower right, no overlap with yellow
        else if (screen_now == overlay_pkg::SCREEN_CHOICE
                 && vcount_in >= `CHOICE_Y0 && vcount_in <= `CHOICE_Y1
                 && hcount_in >= `CHOICE_L_X0 && hcount_in <= `CHOICE_L_X1)
            rgb_nxt = `COL_BLUE;
        else if (screen_now == overlay_pkg::SCREEN_CHOICE
                 && vcount_in >= `CHOICE_Y0 && vcount_in <= `CHOICE_Y1
                 && hcount_in >= `CHOICE_R_X0 && hcount_in <= `CHOICE_R_X1)
            rgb_nxt = `COL_YELLOW;
        else
            hit_nxt = 1'b0;
    end

    always_ff @(posedge pclk)
    begin
        if (rst)
            shape_hit <= 1'b0;
        else
            shape_hit <= hit_nxt;
    end

    always_ff @(posedge pclk)
    begin
        shape_rgb <= rgb_nxt;
    end

endmodule
